//--- flist.f
common/plic_pkg.sv
plic/plic_regs.sv
plic/plic_gateway.sv
plic/plic_target.sv
hw/plic_top.sv
testbench/plic_props.sv
testbench/plic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PLIC testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
    --top-module plic_tb -o plic_sim \
    && ./obj_dir/plic_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/plic_tb.sv
`timescale 1ns/1ps

module plic_tb;

    typedef enum {op_wr, op_rd, op_src, op_irq} tb_op_e;

    typedef struct {
        string       name;
        tb_op_e      op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    localparam int max_wait = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 sel;
    logic [1:0]           irq_src;
    logic [1:0]           irq;
    plic_pkg::dbus2peri_s dbus;
    plic_pkg::peri2dbus_s rsp;

    step_t steps[$];
    int    seed;
    int    pass_cnt;
    int    fail_cnt;
    logic  step_ok;

    plic_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .dbus2plic_i (dbus),
        .plic_sel_i  (sel),
        .plic2dbus_o (rsp),
        .irq_src_i   (irq_src),
        .irq_o       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------

    // PLIC window at 0x0C00_0000
    function automatic logic [31:0] plic_addr(input plic_pkg::plic_reg_e r);
        return {8'h0c, r};
    endfunction

    // Highest priority strictly above threshold wins and a tie goes to the lower identifier
    function automatic logic [31:0] expected_claim(input int p1, input int p2, input int th);
        if (p1 <= th && p2 <= th) begin
            return 0;
        end
        return (p1 >= p2) ? 1 : 2;
    endfunction

    task automatic add_step(input string name, input tb_op_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
        step_t s;
        s.name = name;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            step_ok = 1'b0;
        end
    endtask

    // --------------------
    // Bus and irq tasks
    // --------------------

    task automatic bus_write(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
        dbus.addr   = addr;
        dbus.w_data = data;
        dbus.w_en   = 1'b1;
        dbus.cyc    = 1'b1;
        sel         = 1'b1;
        #1;
        // Write ack is combinational
        check_value({name, " ack"}, 32'd1, {31'd0, rsp.ack});
        @(posedge clk);
        @(negedge clk);
        dbus.cyc  = 1'b0;
        dbus.w_en = 1'b0;
        sel       = 1'b0;
    endtask

    task automatic bus_read(input string name, input logic [31:0] addr,
                            output logic [31:0] data);
        int n;
        dbus.addr = addr;
        dbus.w_en = 1'b0;
        dbus.cyc  = 1'b1;
        sel       = 1'b1;
        n         = 0;
        data      = '0;
        #1;
        // No ack in the cycle the request is presented
        check_value({name, " early ack"}, 32'd0, {31'd0, rsp.ack});
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!rsp.ack && n < max_wait);
        if (!rsp.ack) begin
            $display("%s: read ack never arrived", name);
            step_ok = 1'b0;
        end else begin
            check_value({name, " latency"}, 32'd1, n);
            data = rsp.r_data;
        end
        @(negedge clk);
        dbus.cyc = 1'b0;
        sel      = 1'b0;
        // Idle cycle lets the response register drop its ack
        @(negedge clk);
    endtask

    task automatic wait_irq(input string name, input logic [1:0] want,
                            input logic [31:0] cycles);
        int n;
        n = 0;
        while (irq != want && n < max_wait) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (irq != want) begin
            $display("%s: irq_o never reached 0x%0h", name, want);
            step_ok = 1'b0;
        end else begin
            check_value({name, " cycles"}, cycles, n);
        end
        if (n > 0) begin
            @(negedge clk);
        end
    endtask

    // --------------------
    // Stimulus table
    // --------------------

    task automatic build_table();
        int          p1;
        int          p2;
        int          th;
        logic [31:0] e;
        string       tag;
        add_step("rst_prio1", op_rd, plic_addr(plic_pkg::prio_src1), 0, 0);
        add_step("rst_prio2", op_rd, plic_addr(plic_pkg::prio_src2), 0, 0);
        add_step("rst_pending", op_rd, plic_addr(plic_pkg::pending), 0, 0);
        add_step("rst_enable_t0", op_rd, plic_addr(plic_pkg::enable_t0), 0, 0);
        add_step("rst_enable_t1", op_rd, plic_addr(plic_pkg::enable_t1), 0, 0);
        add_step("rst_thresh_t0", op_rd, plic_addr(plic_pkg::thresh_t0), 0, 0);
        add_step("rst_thresh_t1", op_rd, plic_addr(plic_pkg::thresh_t1), 0, 0);
        add_step("rst_claim_t0", op_rd, plic_addr(plic_pkg::claim_t0), 0, 0);
        add_step("rst_claim_t1", op_rd, plic_addr(plic_pkg::claim_t1), 0, 0);
        add_step("unmapped_rd", op_rd, 32'h0c00_0abc, 0, 0);
        add_step("wr_prio0", op_wr, plic_addr(plic_pkg::prio_src0), 7, 0);
        add_step("prio0_zero", op_rd, plic_addr(plic_pkg::prio_src0), 0, 0);
        add_step("wr_prio1", op_wr, plic_addr(plic_pkg::prio_src1), 'hff, 0);
        add_step("prio1_mask", op_rd, plic_addr(plic_pkg::prio_src1), 0, 7);
        add_step("wr_prio2", op_wr, plic_addr(plic_pkg::prio_src2), 5, 0);
        add_step("wr_enable_t0", op_wr, plic_addr(plic_pkg::enable_t0), 'hffff_ffff, 0);
        add_step("enable_t0_mask", op_rd, plic_addr(plic_pkg::enable_t0), 0, 6);
        add_step("wr_thresh_t1", op_wr, plic_addr(plic_pkg::thresh_t1), 'h1c, 0);
        add_step("thresh_t1_mask", op_rd, plic_addr(plic_pkg::thresh_t1), 0, 4);
        add_step("wr_pending", op_wr, plic_addr(plic_pkg::pending), 'hf, 0);
        add_step("pending_ro", op_rd, plic_addr(plic_pkg::pending), 0, 0);
        // Each target follows its own enable word
        add_step("en_t1_src2", op_wr, plic_addr(plic_pkg::enable_t1), 4, 0);
        add_step("sources_on", op_src, 0, 3, 0);
        add_step("irq_rise", op_irq, 0, 3, 1);
        add_step("pending_both", op_rd, plic_addr(plic_pkg::pending), 0, 6);
        add_step("en_t0_off", op_wr, plic_addr(plic_pkg::enable_t0), 0, 0);
        add_step("irq_t1_only", op_irq, 0, 2, 0);
        add_step("en_t1_off", op_wr, plic_addr(plic_pkg::enable_t1), 0, 0);
        add_step("en_t0_both", op_wr, plic_addr(plic_pkg::enable_t0), 6, 0);
        add_step("irq_t0_only", op_irq, 0, 1, 0);
        // Claim and complete on target 0
        add_step("claim_high", op_rd, plic_addr(plic_pkg::claim_t0), 0, 1);
        add_step("complete_other", op_wr, plic_addr(plic_pkg::claim_t0), 2, 0);
        add_step("pending_after", op_rd, plic_addr(plic_pkg::pending), 0, 4);
        add_step("claim_second", op_rd, plic_addr(plic_pkg::claim_t0), 0, 2);
        add_step("irq_all_claimed", op_irq, 0, 0, 0);
        add_step("claim_empty", op_rd, plic_addr(plic_pkg::claim_t0), 0, 0);
        add_step("complete_src1", op_wr, plic_addr(plic_pkg::claim_t0), 1, 0);
        add_step("irq_repend", op_irq, 0, 1, 1);
        add_step("complete_src2", op_wr, plic_addr(plic_pkg::claim_t0), 2, 0);
        add_step("prio2_tie", op_wr, plic_addr(plic_pkg::prio_src2), 7, 0);
        add_step("claim_tie", op_rd, plic_addr(plic_pkg::claim_t0), 0, 1);
        add_step("complete_tie", op_wr, plic_addr(plic_pkg::claim_t0), 1, 0);
        add_step("thresh_high", op_wr, plic_addr(plic_pkg::thresh_t0), 7, 0);
        add_step("irq_thresh", op_irq, 0, 0, 0);
        add_step("claim_thresh", op_rd, plic_addr(plic_pkg::claim_t0), 0, 0);
        add_step("thresh_low", op_wr, plic_addr(plic_pkg::thresh_t0), 0, 0);
        add_step("irq_thresh_low", op_irq, 0, 1, 0);
        // Random priorities and thresholds with both sources kept pending
        for (int i = 0; i < 6; i++) begin
            p1  = $random(seed) & 7;
            p2  = $random(seed) & 7;
            th  = $random(seed) & 7;
            e   = expected_claim(p1, p2, th);
            tag = $sformatf("rand%0d", i);
            add_step({tag, "_p1"}, op_wr, plic_addr(plic_pkg::prio_src1), p1, 0);
            add_step({tag, "_p2"}, op_wr, plic_addr(plic_pkg::prio_src2), p2, 0);
            add_step({tag, "_th"}, op_wr, plic_addr(plic_pkg::thresh_t0), th, 0);
            add_step({tag, "_claim"}, op_rd, plic_addr(plic_pkg::claim_t0), 0, e);
            if (e != 0) begin
                add_step({tag, "_done"}, op_wr, plic_addr(plic_pkg::claim_t0), e, 0);
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        logic [31:0] rd_data;
        dbus     = '0;
        sel      = 1'b0;
        irq_src  = '0;
        rst_n    = 1'b0;
        seed     = 1;
        pass_cnt = 0;
        fail_cnt = 0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            step_ok = 1'b1;
            case (steps[i].op)
                op_wr:  bus_write(steps[i].name, steps[i].addr, steps[i].data);
                op_rd: begin
                    bus_read(steps[i].name, steps[i].addr, rd_data);
                    check_value(steps[i].name, steps[i].exp, rd_data);
                end
                op_src: irq_src = steps[i].data[1:0];
                default: wait_irq(steps[i].name, steps[i].data[1:0], steps[i].exp);
            endcase
            if (step_ok) begin
                pass_cnt++;
                $display("%s: ok", steps[i].name);
            end else begin
                fail_cnt++;
                $display("%s: failed", steps[i].name);
            end
        end
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/plic_props.sv
`timescale 1ns/1ps

module plic_props (
    input logic       clk,
    input logic       rst_n,
    input logic       rd_ack,
    input logic [1:0] claim_req,
    input logic [1:0] irq
);

    // Read acks always have an idle cycle between them
    assert property (@(posedge clk) disable iff (!rst_n) rd_ack |=> !rd_ack)
        else $error("read ack high for two cycles in a row");

    // All priorities are zero out of reset
    assert property (@(posedge clk) $rose(rst_n) |-> irq == '0)
        else $error("irq_o high in the cycle after reset release");

    assert property (@(posedge clk) disable iff (!rst_n)
                     (claim_req & $past(claim_req)) == '0)
        else $error("claim pulse lasted longer than one cycle");

endmodule

// Read ack is the bus ack outside of a write cycle
bind plic_top plic_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_ack    (plic2dbus_o.ack && !(dbus2plic_i.cyc && plic_sel_i && dbus2plic_i.w_en)),
    .claim_req (regs2gateway.claim_req),
    .irq       (irq_o)
);

//--- hw/plic_top.sv
`timescale 1ns/1ps

module plic_top (
    input  logic                                     clk,
    input  logic                                     rst_n,

    // Data bus
    input  plic_pkg::dbus2peri_s                     dbus2plic_i,
    input  logic                                     plic_sel_i,
    output plic_pkg::peri2dbus_s                     plic2dbus_o,

    // Level sources in, interrupt lines out
    input  logic [plic_pkg::plic_source_count-1:0]   irq_src_i,
    output logic [plic_pkg::plic_target_count-1:0]   irq_o
);

    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_source_count-1:0] regs_ie;
    logic [plic_pkg::plic_source_count-1:0][plic_pkg::plic_prio_width-1:0]   regs_prio;
    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_prio_width-1:0]   regs_prio_th;
    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_source_width-1:0] claim_idx;
    logic [plic_pkg::plic_source_count-1:0]                                  irq_pending;
    plic_pkg::regs2gateway_s                                                 regs2gateway;

    plic_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .dbus2plic_i    (dbus2plic_i),
        .plic_sel_i     (plic_sel_i),
        .plic2dbus_o    (plic2dbus_o),
        .irq_pending_i  (irq_pending),
        .claim_idx_i    (claim_idx),
        .regs_ie_o      (regs_ie),
        .regs_prio_o    (regs_prio),
        .regs_prio_th_o (regs_prio_th),
        .regs2gateway_o (regs2gateway)
    );

    plic_gateway u_gateway (
        .clk            (clk),
        .rst_n          (rst_n),
        .irq_src_i      (irq_src_i),
        .regs2gateway_i (regs2gateway),
        .claim_idx_i    (claim_idx),
        .irq_pending_o  (irq_pending)
    );

    plic_target u_target (
        .irq_pending_i  (irq_pending),
        .regs_ie_i      (regs_ie),
        .regs_prio_i    (regs_prio),
        .regs_prio_th_i (regs_prio_th),
        .claim_idx_o    (claim_idx),
        .irq_o          (irq_o)
    );

endmodule

//--- plic/plic_target.sv
`timescale 1ns/1ps

module plic_target (
    input  logic [plic_pkg::plic_source_count-1:0]   irq_pending_i,
    input  logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_source_count-1:0]   regs_ie_i,
    input  logic [plic_pkg::plic_source_count-1:0]
                 [plic_pkg::plic_prio_width-1:0]     regs_prio_i,
    input  logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_prio_width-1:0]     regs_prio_th_i,
    output logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_source_width-1:0]   claim_idx_o,
    output logic [plic_pkg::plic_target_count-1:0]   irq_o
);

    // Running best priority seeded with the threshold
    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_prio_width-1:0] best_prio;

    // --------------------
    // Best source per target
    // --------------------

    // Ascending scan with a strict compare, so ties keep the lower identifier.
    // Seeding with the threshold makes "above threshold" fall out of the compare
    always_comb begin
        for (int t = 0; t < plic_pkg::plic_target_count; t++) begin
            best_prio[t]   = regs_prio_th_i[t];
            claim_idx_o[t] = '0;
            for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
                if (irq_pending_i[s] && regs_ie_i[t][s] &&
                    regs_prio_i[s] > best_prio[t]) begin
                    best_prio[t]   = regs_prio_i[s];
                    claim_idx_o[t] = plic_pkg::plic_source_width'(s + 1);
                end
            end
        end
    end

    // Interrupt line per target
    always_comb begin
        for (int t = 0; t < plic_pkg::plic_target_count; t++) begin
            irq_o[t] = (claim_idx_o[t] != '0);
        end
    end

endmodule

//--- plic/plic_gateway.sv
`timescale 1ns/1ps

module plic_gateway (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [plic_pkg::plic_source_count-1:0]   irq_src_i,
    input  plic_pkg::regs2gateway_s                  regs2gateway_i,
    input  logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_source_width-1:0]   claim_idx_i,
    output logic [plic_pkg::plic_source_count-1:0]   irq_pending_o
);

    plic_pkg::gw_state_e                        state_q [plic_pkg::plic_source_count];
    plic_pkg::gw_state_e                        state_d [plic_pkg::plic_source_count];
    logic [plic_pkg::plic_source_count-1:0]     claim_hit;
    logic [plic_pkg::plic_source_count-1:0]     complete_hit;

    // Array index s carries source identifier s + 1
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
            for (int t = 0; t < plic_pkg::plic_target_count; t++) begin
                if (regs2gateway_i.claim_req[t] &&
                    claim_idx_i[t] == plic_pkg::plic_source_width'(s + 1)) begin
                    claim_hit[s] = 1'b1;
                end
                if (regs2gateway_i.complete_req[t] &&
                    regs2gateway_i.complete_idx[t] == plic_pkg::plic_source_width'(s + 1)) begin
                    complete_hit[s] = 1'b1;
                end
            end
        end
    end

    // --------------------
    // Request latch per source
    // --------------------

    always_comb begin
        for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
            state_d[s] = state_q[s];
            case (state_q[s])
                plic_pkg::gw_idle:       if (irq_src_i[s])    state_d[s] = plic_pkg::gw_pending;
                plic_pkg::gw_pending:    if (claim_hit[s])    state_d[s] = plic_pkg::gw_in_service;
                // Held here until the handler completes, so no second claim
                plic_pkg::gw_in_service: if (complete_hit[s]) state_d[s] = plic_pkg::gw_idle;
                default:                 state_d[s] = plic_pkg::gw_idle;
            endcase
            irq_pending_o[s] = (state_q[s] == plic_pkg::gw_pending);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
                state_q[s] <= plic_pkg::gw_idle;
            end
        end else begin
            for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
                state_q[s] <= state_d[s];
            end
        end
    end

endmodule

//--- plic/plic_regs.sv
`timescale 1ns/1ps

module plic_regs (
    input  logic                                     clk,
    input  logic                                     rst_n,

    // Data bus
    input  plic_pkg::dbus2peri_s                     dbus2plic_i,
    input  logic                                     plic_sel_i,
    output plic_pkg::peri2dbus_s                     plic2dbus_o,

    // Status from gateways and target selection
    input  logic [plic_pkg::plic_source_count-1:0]   irq_pending_i,
    input  logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_source_width-1:0]   claim_idx_i,

    // Configuration out
    output logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_source_count-1:0]   regs_ie_o,
    output logic [plic_pkg::plic_source_count-1:0]
                 [plic_pkg::plic_prio_width-1:0]     regs_prio_o,
    output logic [plic_pkg::plic_target_count-1:0]
                 [plic_pkg::plic_prio_width-1:0]     regs_prio_th_o,
    output plic_pkg::regs2gateway_s                  regs2gateway_o
);

    plic_pkg::plic_reg_e                          reg_addr;
    logic [plic_pkg::xlen-1:0]                    reg_w_data;
    logic [plic_pkg::xlen-1:0]                    reg_r_data;
    logic                                         reg_rd_req;
    logic                                         reg_wr_req;

    logic [plic_pkg::plic_source_count-1:0]       prio_wr_flag;
    logic [plic_pkg::plic_target_count-1:0]       ie_wr_flag;
    logic [plic_pkg::plic_target_count-1:0]       th_wr_flag;

    logic [plic_pkg::plic_source_count-1:0][plic_pkg::plic_prio_width-1:0]   prio_q;
    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_source_count-1:0] ie_q;
    logic [plic_pkg::plic_target_count-1:0][plic_pkg::plic_prio_width-1:0]   th_q;

    plic_pkg::peri2dbus_s                         rsp_q;

    // Only the low offset bits are decoded
    assign reg_addr   = plic_pkg::plic_reg_e'(
                            dbus2plic_i.addr[plic_pkg::plic_reg_offset_width-1:0]);
    assign reg_w_data = dbus2plic_i.w_data;
    assign reg_rd_req = dbus2plic_i.cyc && plic_sel_i && !dbus2plic_i.w_en;
    assign reg_wr_req = dbus2plic_i.cyc && plic_sel_i && dbus2plic_i.w_en;

    // --------------------
    // Read decode
    // --------------------

    always_comb begin
        reg_r_data                  = '0;
        regs2gateway_o.claim_req    = '0;
        if (reg_rd_req) begin
            case (reg_addr)
                plic_pkg::prio_src1: reg_r_data[plic_pkg::plic_prio_width-1:0] = prio_q[0];
                plic_pkg::prio_src2: reg_r_data[plic_pkg::plic_prio_width-1:0] = prio_q[1];
                // Bit 0 stands for the reserved source
                plic_pkg::pending:   reg_r_data[plic_pkg::plic_source_count:0] = {irq_pending_i, 1'b0};
                plic_pkg::enable_t0: reg_r_data[plic_pkg::plic_source_count:0] = {ie_q[0], 1'b0};
                plic_pkg::enable_t1: reg_r_data[plic_pkg::plic_source_count:0] = {ie_q[1], 1'b0};
                plic_pkg::thresh_t0: reg_r_data[plic_pkg::plic_prio_width-1:0] = th_q[0];
                plic_pkg::thresh_t1: reg_r_data[plic_pkg::plic_prio_width-1:0] = th_q[1];
                plic_pkg::claim_t0: begin
                    reg_r_data[plic_pkg::plic_source_width-1:0] = claim_idx_i[0];
                    // The ack masks all but the first cycle of a read
                    regs2gateway_o.claim_req[0] = !rsp_q.ack;
                end
                plic_pkg::claim_t1: begin
                    reg_r_data[plic_pkg::plic_source_width-1:0] = claim_idx_i[1];
                    regs2gateway_o.claim_req[1] = !rsp_q.ack;
                end
                default: reg_r_data = '0;
            endcase
        end
    end

    // --------------------
    // Write decode
    // --------------------

    always_comb begin
        prio_wr_flag                = '0;
        ie_wr_flag                  = '0;
        th_wr_flag                  = '0;
        regs2gateway_o.complete_req = '0;
        regs2gateway_o.complete_idx = '0;
        if (reg_wr_req) begin
            case (reg_addr)
                plic_pkg::prio_src1: prio_wr_flag[0] = 1'b1;
                plic_pkg::prio_src2: prio_wr_flag[1] = 1'b1;
                plic_pkg::enable_t0: ie_wr_flag[0]   = 1'b1;
                plic_pkg::enable_t1: ie_wr_flag[1]   = 1'b1;
                plic_pkg::thresh_t0: th_wr_flag[0]   = 1'b1;
                plic_pkg::thresh_t1: th_wr_flag[1]   = 1'b1;
                plic_pkg::claim_t0: begin
                    regs2gateway_o.complete_req[0] = 1'b1;
                    regs2gateway_o.complete_idx[0] =
                        reg_w_data[plic_pkg::plic_source_width-1:0];
                end
                plic_pkg::claim_t1: begin
                    regs2gateway_o.complete_req[1] = 1'b1;
                    regs2gateway_o.complete_idx[1] =
                        reg_w_data[plic_pkg::plic_source_width-1:0];
                end
                // prio_src0, pending and unmapped offsets drop the write
                default: ;
            endcase
        end
    end

    // --------------------
    // Configuration registers
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q <= '0;
            ie_q   <= '0;
            th_q   <= '0;
        end else begin
            for (int s = 0; s < plic_pkg::plic_source_count; s++) begin
                if (prio_wr_flag[s]) begin
                    prio_q[s] <= reg_w_data[plic_pkg::plic_prio_width-1:0];
                end
            end
            for (int t = 0; t < plic_pkg::plic_target_count; t++) begin
                // Enable bits line up with source identifiers
                if (ie_wr_flag[t]) begin
                    ie_q[t] <= reg_w_data[plic_pkg::plic_source_count:1];
                end
                if (th_wr_flag[t]) begin
                    th_q[t] <= reg_w_data[plic_pkg::plic_prio_width-1:0];
                end
            end
        end
    end

    // The read ack drops for a cycle after each read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q <= '0;
        end else begin
            rsp_q.ack    <= reg_rd_req && !rsp_q.ack;
            rsp_q.r_data <= reg_r_data;
        end
    end

    assign plic2dbus_o.r_data = rsp_q.r_data;
    assign plic2dbus_o.ack    = reg_wr_req || rsp_q.ack;

    assign regs_ie_o      = ie_q;
    assign regs_prio_o    = prio_q;
    assign regs_prio_th_o = th_q;

endmodule

//--- common/plic_pkg.sv
package plic_pkg;

    // --------------------
    // Sizes
    // --------------------

    // Source 0 is reserved, so the live sources are 1 and 2
    localparam int plic_source_count     = 2;
    localparam int plic_target_count     = 2;
    localparam int plic_source_width     = 2;
    localparam int plic_prio_width       = 3;
    localparam int plic_reg_offset_width = 24;
    localparam int xlen                  = 32;

    // --------------------
    // Register map
    // --------------------

    typedef enum logic [plic_reg_offset_width-1:0] {
        prio_src0 = 24'h000000,
        prio_src1 = 24'h000004,
        prio_src2 = 24'h000008,
        pending   = 24'h001000,
        enable_t0 = 24'h002000,
        enable_t1 = 24'h002080,
        thresh_t0 = 24'h200000,
        claim_t0  = 24'h200004,
        thresh_t1 = 24'h201000,
        claim_t1  = 24'h201004
    } plic_reg_e;

    // Per-source gateway state
    typedef enum logic [1:0] {
        gw_idle,
        gw_pending,
        gw_in_service
    } gw_state_e;

    // --------------------
    // Bus structs
    // --------------------

    // Request side driven by the data bus master
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] w_data;
        logic            w_en;
        logic            cyc;
    } dbus2peri_s;

    // Reply side
    typedef struct packed {
        logic [xlen-1:0] r_data;
        logic            ack;
    } peri2dbus_s;

    // --------------------
    // Register block to gateways
    // --------------------

    // Claim pulses on the first cycle of a claim read,
    // complete pulses on the write of an identifier
    typedef struct packed {
        logic [plic_target_count-1:0]                        claim_req;
        logic [plic_target_count-1:0]                        complete_req;
        logic [plic_target_count-1:0][plic_source_width-1:0] complete_idx;
    } regs2gateway_s;

endpackage
